/* flist.f */
design/dma_pkg.sv
design/dma_cfg_if.sv
design/dma_regs.sv
design/dma_engine.sv
design/dma_top.sv
tb/axi_mem_model.sv
tb/tb_dma.sv

/* run_sim.sh */
#!/bin/sh
# build the dma testbench with verilator, run it, look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_dma -Mdir obj_dir -f flist.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_dma > sim.log 2>&1
cat sim.log
grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/tb_dma.sv */
`default_nettype none

module tb_dma;
    import dma_pkg::*;

    localparam int QTY_W   = 16;
    localparam int SEED    = 59;
    localparam int DEPTH   = 256;
    localparam int TIMEOUT = 2000;
    // where the cpu sees the register window
    localparam logic [ADDR_W-1:0] REG_BASE = 32'h4000_0000;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] s_awaddr;
    logic [ADDR_W-1:0] s_araddr;
    logic [DATA_W-1:0] s_wdata;
    logic [DATA_W-1:0] s_rdata;
    logic              s_awvalid, s_awready, s_wvalid, s_wready;
    logic              s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;
    axi_resp_t         s_bresp, s_rresp;
    logic [ADDR_W-1:0] m_awaddr, m_araddr;
    logic [DATA_W-1:0] m_wdata, m_rdata;
    logic              m_awvalid, m_awready, m_wvalid, m_wready;
    logic              m_bvalid, m_bready, m_arvalid, m_arready, m_rvalid, m_rready;
    axi_resp_t         m_bresp, m_rresp;
    logic              irq;
    logic              err_en;
    logic [ADDR_W-1:0] err_addr;
    int                seed = SEED;
    // expected memory contents
    logic [DATA_W-1:0] ref_mem [DEPTH];

    dma_top #(
        .QTY_W (QTY_W)
    ) dma_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_wdata_i   (s_wdata),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_bresp_o   (s_bresp),
        .s_bvalid_o  (s_bvalid),
        .s_bready_i  (s_bready),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rresp_o   (s_rresp),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready),
        .m_awaddr_o  (m_awaddr),
        .m_awvalid_o (m_awvalid),
        .m_awready_i (m_awready),
        .m_wdata_o   (m_wdata),
        .m_wvalid_o  (m_wvalid),
        .m_wready_i  (m_wready),
        .m_bresp_i   (m_bresp),
        .m_bvalid_i  (m_bvalid),
        .m_bready_o  (m_bready),
        .m_araddr_o  (m_araddr),
        .m_arvalid_o (m_arvalid),
        .m_arready_i (m_arready),
        .m_rdata_i   (m_rdata),
        .m_rresp_i   (m_rresp),
        .m_rvalid_i  (m_rvalid),
        .m_rready_o  (m_rready),
        .int_o       (irq)
    );

    axi_mem_model #(
        .SEED  (SEED),
        .DEPTH (DEPTH)
    ) mem_inst (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .awaddr_i   (m_awaddr),
        .awvalid_i  (m_awvalid),
        .awready_o  (m_awready),
        .wdata_i    (m_wdata),
        .wvalid_i   (m_wvalid),
        .wready_o   (m_wready),
        .bresp_o    (m_bresp),
        .bvalid_o   (m_bvalid),
        .bready_i   (m_bready),
        .araddr_i   (m_araddr),
        .arvalid_i  (m_arvalid),
        .arready_o  (m_arready),
        .rdata_o    (m_rdata),
        .rresp_o    (m_rresp),
        .rvalid_o   (m_rvalid),
        .rready_i   (m_rready),
        .err_en_i   (err_en),
        .err_addr_i (err_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_stop();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        fail_stop();
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            fail_stop();
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % 32'(n));
    endfunction

    // cpu write, drive on the rising edge, look at ready on the falling edge
    task automatic axi_write(input logic [REG_AW-1:0] off, input logic [DATA_W-1:0] data);
        int n;
        @(posedge clk);
        s_awaddr  <= REG_BASE | ADDR_W'(off);
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wvalid  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("register write was never accepted");
        end while (!s_awready);
        // aw and w ready come as one pulse
        check_flag("s_wready_o", 1'b1, s_wready);
        @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("no write response from the registers");
        end while (!s_bvalid);
        check_resp("s_bresp_o", OKAY, s_bresp);
        @(posedge clk);
        s_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [REG_AW-1:0] off, output logic [DATA_W-1:0] data);
        int n;
        @(posedge clk);
        s_araddr  <= REG_BASE | ADDR_W'(off);
        s_arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("register read was never accepted");
        end while (!s_arready);
        @(posedge clk);
        s_arvalid <= 1'b0;
        s_rready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("no read data from the registers");
        end while (!s_rvalid);
        data = s_rdata;
        check_resp("s_rresp_o", OKAY, s_rresp);
        @(posedge clk);
        s_rready <= 1'b0;
    endtask

    task automatic check_status(input logic busy, input logic done, input logic err);
        logic [DATA_W-1:0] st;
        axi_read(REG_CTRL, st);
        check_flag("status busy", busy, st[STAT_BUSY_BIT]);
        check_flag("status done", done, st[STAT_DONE_BIT]);
        check_flag("status err", err, st[STAT_ERR_BIT]);
    endtask

    task automatic start_copy(input int src_w, input int dst_w, input int qty);
        axi_write(REG_SRC, ADDR_W'(src_w * 4));
        axi_write(REG_DST, ADDR_W'(dst_w * 4));
        axi_write(REG_QTY, DATA_W'(qty));
        axi_write(REG_CTRL, DATA_W'(1) << CTRL_START_BIT);
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("int_o never rose after start");
        end while (!irq);
    endtask

    // copy rule, word after word from source to destination
    function automatic void model_copy(input int src_w, input int dst_w, input int n);
        for (int i = 0; i < n; i++) begin
            ref_mem[dst_w + i] = ref_mem[src_w + i];
        end
    endfunction

    task automatic check_memory();
        for (int i = 0; i < DEPTH; i++) begin
            check_word($sformatf("mem[%0d]", i), ref_mem[i], mem_inst.mem[i]);
        end
    endtask

    initial begin
        int                src_w;
        int                dst_w;
        int                qty;
        int                k;
        logic [DATA_W-1:0] wr;
        logic [DATA_W-1:0] rd;
        rst_n     <= 1'b0;
        s_awaddr  <= '0;
        s_awvalid <= 1'b0;
        s_wdata   <= '0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b0;
        s_araddr  <= '0;
        s_arvalid <= 1'b0;
        s_rready  <= 1'b0;
        err_en    <= 1'b0;
        err_addr  <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = mem_inst.mem[i];
        end

        // reset state and register readback
        check_flag("int_o", 1'b0, irq);
        check_status(1'b0, 1'b0, 1'b0);
        wr = $random(seed);
        axi_write(REG_SRC, wr);
        axi_read(REG_SRC, rd);
        check_word("src_addr", wr, rd);
        wr = $random(seed);
        axi_write(REG_DST, wr);
        axi_read(REG_DST, rd);
        check_word("dst_addr", wr, rd);
        wr = $random(seed);
        axi_write(REG_QTY, wr);
        axi_read(REG_QTY, rd);
        check_word("qty", DATA_W'(wr[QTY_W-1:0]), rd);
        axi_read(5'h14, rd);
        check_word("unmapped offset", '0, rd);

        // plain copy under random stalls
        src_w = rand_below(32);
        dst_w = 128 + rand_below(32);
        qty   = 1 + rand_below(20);
        start_copy(src_w, dst_w, qty);
        wait_irq();
        model_copy(src_w, dst_w, qty);
        check_memory();
        check_status(1'b0, 1'b1, 1'b0);
        // still high after the status read, so it is sticky
        check_flag("int_o", 1'b1, irq);

        // write 1 to done clears it and the interrupt
        axi_write(REG_CTRL, DATA_W'(1) << STAT_DONE_BIT);
        check_flag("int_o", 1'b0, irq);
        check_status(1'b0, 1'b0, 1'b0);

        // empty copy, memory untouched
        start_copy(rand_below(32), 128 + rand_below(32), 0);
        wait_irq();
        check_memory();
        check_status(1'b0, 1'b1, 1'b0);
        axi_write(REG_CTRL, DATA_W'(1) << STAT_DONE_BIT);

        // second start mid copy with a new count must be dropped
        src_w = 32 + rand_below(32);
        dst_w = 192 + rand_below(32);
        qty   = 10 + rand_below(10);
        start_copy(src_w, dst_w, qty);
        check_status(1'b1, 1'b0, 1'b0);
        axi_write(REG_QTY, DATA_W'(3));
        axi_write(REG_CTRL, DATA_W'(1) << CTRL_START_BIT);
        wait_irq();
        model_copy(src_w, dst_w, qty);
        check_memory();
        check_status(1'b0, 1'b1, 1'b0);
        axi_write(REG_CTRL, DATA_W'(1) << STAT_DONE_BIT);

        // error on the write of word k
        src_w = rand_below(32);
        dst_w = 160 + rand_below(32);
        qty   = 4 + rand_below(12);
        k     = rand_below(qty);
        @(posedge clk);
        err_en   <= 1'b1;
        err_addr <= ADDR_W'((dst_w + k) * 4);
        start_copy(src_w, dst_w, qty);
        wait_irq();
        model_copy(src_w, dst_w, k);
        check_memory();
        check_status(1'b0, 1'b1, 1'b1);
        check_flag("int_o", 1'b1, irq);
        @(posedge clk);
        err_en <= 1'b0;
        axi_write(REG_CTRL, DATA_W'(1) << STAT_DONE_BIT);
        check_status(1'b0, 1'b0, 1'b0);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/axi_mem_model.sv */
`default_nettype none

module axi_mem_model #(
    parameter int SEED     = 59,
    parameter int DEPTH    = 256,
    parameter int MAX_WAIT = 3
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [dma_pkg::ADDR_W-1:0] awaddr_i,
    input  logic                       awvalid_i,
    output logic                       awready_o,
    input  logic [dma_pkg::DATA_W-1:0] wdata_i,
    input  logic                       wvalid_i,
    output logic                       wready_o,
    output dma_pkg::axi_resp_t         bresp_o,
    output logic                       bvalid_o,
    input  logic                       bready_i,
    input  logic [dma_pkg::ADDR_W-1:0] araddr_i,
    input  logic                       arvalid_i,
    output logic                       arready_o,
    output logic [dma_pkg::DATA_W-1:0] rdata_o,
    output dma_pkg::axi_resp_t         rresp_o,
    output logic                       rvalid_o,
    input  logic                       rready_i,
    // a write to err_addr_i answers SLVERR and leaves memory alone
    input  logic                       err_en_i,
    input  logic [dma_pkg::ADDR_W-1:0] err_addr_i
);
    import dma_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] awaddr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              aw_got;
    logic              w_got;
    int                seed = SEED;
    int                ar_wait;
    int                aw_wait;
    int                w_wait;

    // byte address to word slot, wraps over the depth
    function automatic int word_index(input logic [ADDR_W-1:0] addr);
        return int'(addr[ADDR_W-1:2]) % DEPTH;
    endfunction

    // idle cycles before the next ready pulse
    function automatic int pick_wait();
        return int'($unsigned($random(seed)) % (MAX_WAIT + 1));
    endfunction

    // random contents at start
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= $random(seed);
        end
    end

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= OKAY;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            bresp_o   <= OKAY;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            ar_wait   <= 0;
            aw_wait   <= 0;
            w_wait    <= 0;
        end else begin
            // read, data one cycle after the address handshake
            if (arready_o) begin
                arready_o <= 1'b0;
                rvalid_o  <= 1'b1;
                rdata_o   <= mem[word_index(araddr_i)];
                rresp_o   <= OKAY;
            end else if (rvalid_o) begin
                if (rready_i) begin
                    rvalid_o <= 1'b0;
                end
            end else if (arvalid_i && ar_wait == 0) begin
                arready_o <= 1'b1;
                ar_wait   <= pick_wait();
            end else if (arvalid_i) begin
                ar_wait <= ar_wait - 1;
            end
            // aw and w each with their own stall
            if (awready_o) begin
                awready_o <= 1'b0;
                aw_got    <= 1'b1;
                awaddr_q  <= awaddr_i;
            end else if (awvalid_i && !aw_got && aw_wait == 0) begin
                awready_o <= 1'b1;
                aw_wait   <= pick_wait();
            end else if (awvalid_i && !aw_got) begin
                aw_wait <= aw_wait - 1;
            end
            if (wready_o) begin
                wready_o <= 1'b0;
                w_got    <= 1'b1;
                wdata_q  <= wdata_i;
            end else if (wvalid_i && !w_got && w_wait == 0) begin
                wready_o <= 1'b1;
                w_wait   <= pick_wait();
            end else if (wvalid_i && !w_got) begin
                w_wait <= w_wait - 1;
            end
            // response once both halves are in
            if (bvalid_o) begin
                if (bready_i) begin
                    bvalid_o <= 1'b0;
                end
            end else if (aw_got && w_got) begin
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
                bvalid_o <= 1'b1;
                if (err_en_i && awaddr_q == err_addr_i) begin
                    bresp_o <= SLVERR;
                end else begin
                    bresp_o                  <= OKAY;
                    mem[word_index(awaddr_q)] <= wdata_q;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/dma_top.sv */
`default_nettype none

module dma_top #(
    parameter int QTY_W = 16
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // cpu register port
    input  logic [dma_pkg::ADDR_W-1:0] s_awaddr_i,
    input  logic                       s_awvalid_i,
    output logic                       s_awready_o,
    input  logic [dma_pkg::DATA_W-1:0] s_wdata_i,
    input  logic                       s_wvalid_i,
    output logic                       s_wready_o,
    output dma_pkg::axi_resp_t         s_bresp_o,
    output logic                       s_bvalid_o,
    input  logic                       s_bready_i,
    input  logic [dma_pkg::ADDR_W-1:0] s_araddr_i,
    input  logic                       s_arvalid_i,
    output logic                       s_arready_o,
    output logic [dma_pkg::DATA_W-1:0] s_rdata_o,
    output dma_pkg::axi_resp_t         s_rresp_o,
    output logic                       s_rvalid_o,
    input  logic                       s_rready_i,
    // memory port
    output logic [dma_pkg::ADDR_W-1:0] m_awaddr_o,
    output logic                       m_awvalid_o,
    input  logic                       m_awready_i,
    output logic [dma_pkg::DATA_W-1:0] m_wdata_o,
    output logic                       m_wvalid_o,
    input  logic                       m_wready_i,
    input  dma_pkg::axi_resp_t         m_bresp_i,
    input  logic                       m_bvalid_i,
    output logic                       m_bready_o,
    output logic [dma_pkg::ADDR_W-1:0] m_araddr_o,
    output logic                       m_arvalid_o,
    input  logic                       m_arready_i,
    input  logic [dma_pkg::DATA_W-1:0] m_rdata_i,
    input  dma_pkg::axi_resp_t         m_rresp_i,
    input  logic                       m_rvalid_i,
    output logic                       m_rready_o,
    // copy finished, sticky until cleared
    output logic                       int_o
);

    // config and status between regs and engine
    dma_cfg_if #(.QTY_W(QTY_W)) cfg_if ();

    dma_regs #(
        .QTY_W (QTY_W)
    ) dma_regs_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .cfg_o       (cfg_if.regs),
        .int_o       (int_o)
    );

    dma_engine #(
        .QTY_W (QTY_W)
    ) dma_engine_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg_if.engine),
        .m_awaddr_o  (m_awaddr_o),
        .m_awvalid_o (m_awvalid_o),
        .m_awready_i (m_awready_i),
        .m_wdata_o   (m_wdata_o),
        .m_wvalid_o  (m_wvalid_o),
        .m_wready_i  (m_wready_i),
        .m_bresp_i   (m_bresp_i),
        .m_bvalid_i  (m_bvalid_i),
        .m_bready_o  (m_bready_o),
        .m_araddr_o  (m_araddr_o),
        .m_arvalid_o (m_arvalid_o),
        .m_arready_i (m_arready_i),
        .m_rdata_i   (m_rdata_i),
        .m_rresp_i   (m_rresp_i),
        .m_rvalid_i  (m_rvalid_i),
        .m_rready_o  (m_rready_o)
    );

endmodule

`default_nettype wire

/* design/dma_engine.sv */
`default_nettype none

module dma_engine #(
    parameter int QTY_W = 16
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    dma_cfg_if.engine                  cfg_i,
    // axi4-lite master, memory side
    output logic [dma_pkg::ADDR_W-1:0] m_awaddr_o,
    output logic                       m_awvalid_o,
    input  logic                       m_awready_i,
    output logic [dma_pkg::DATA_W-1:0] m_wdata_o,
    output logic                       m_wvalid_o,
    input  logic                       m_wready_i,
    input  dma_pkg::axi_resp_t         m_bresp_i,
    input  logic                       m_bvalid_i,
    output logic                       m_bready_o,
    output logic [dma_pkg::ADDR_W-1:0] m_araddr_o,
    output logic                       m_arvalid_o,
    input  logic                       m_arready_i,
    input  logic [dma_pkg::DATA_W-1:0] m_rdata_i,
    input  dma_pkg::axi_resp_t         m_rresp_i,
    input  logic                       m_rvalid_i,
    output logic                       m_rready_o
);
    import dma_pkg::*;

    dma_state_t        state_q;
    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic [QTY_W-1:0]  cnt_q;
    logic [DATA_W-1:0] data_q;
    logic              aw_seen_q;
    logic              w_seen_q;
    logic              done_q;
    logic              err_q;
    logic              aw_hs;
    logic              w_hs;
    logic              wr_req_ok;

    assign aw_hs = m_awvalid_o && m_awready_i;
    assign w_hs  = m_wvalid_o && m_wready_i;
    // both write channels taken, this cycle or earlier
    assign wr_req_ok = (aw_seen_q || aw_hs) && (w_seen_q || w_hs);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            aw_seen_q <= 1'b0;
            w_seen_q  <= 1'b0;
            done_q    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cfg_i.start) begin
                        err_q <= 1'b0;
                        // empty copy goes straight to the done pulse
                        state_q <= (cfg_i.qty == '0) ? FINISH : RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (m_arready_i) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (m_rvalid_i) begin
                        if (m_rresp_i != OKAY) begin
                            err_q   <= 1'b1;
                            state_q <= FINISH;
                        end else begin
                            state_q <= WR_REQ;
                        end
                    end
                end
                WR_REQ: begin
                    // aw and w finish independently
                    if (wr_req_ok) begin
                        aw_seen_q <= 1'b0;
                        w_seen_q  <= 1'b0;
                        state_q   <= WR_RESP;
                    end else begin
                        if (aw_hs) begin
                            aw_seen_q <= 1'b1;
                        end
                        if (w_hs) begin
                            w_seen_q <= 1'b1;
                        end
                    end
                end
                WR_RESP: begin
                    if (m_bvalid_i) begin
                        if (m_bresp_i != OKAY) begin
                            err_q   <= 1'b1;
                            state_q <= FINISH;
                        end else if (cnt_q == QTY_W'(1)) begin
                            state_q <= FINISH;
                        end else begin
                            state_q <= RD_ADDR;
                        end
                    end
                end
                FINISH: begin
                    // done lands with busy already low
                    done_q  <= 1'b1;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // addresses, remaining count, word buffer
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cfg_i.start) begin
            src_q <= cfg_i.src_addr;
            dst_q <= cfg_i.dst_addr;
            cnt_q <= cfg_i.qty;
        end
        if (state_q == RD_DATA && m_rvalid_i) begin
            data_q <= m_rdata_i;
        end
        // next word after a good write response
        if (state_q == WR_RESP && m_bvalid_i && m_bresp_i == OKAY) begin
            src_q <= src_q + ADDR_W'(4);
            dst_q <= dst_q + ADDR_W'(4);
            cnt_q <= cnt_q - QTY_W'(1);
        end
    end

    assign m_araddr_o  = src_q;
    assign m_arvalid_o = (state_q == RD_ADDR);
    assign m_rready_o  = (state_q == RD_DATA);
    assign m_awaddr_o  = dst_q;
    assign m_awvalid_o = (state_q == WR_REQ) && !aw_seen_q;
    assign m_wdata_o   = data_q;
    assign m_wvalid_o  = (state_q == WR_REQ) && !w_seen_q;
    assign m_bready_o  = (state_q == WR_RESP);

    assign cfg_i.busy = (state_q != IDLE);
    assign cfg_i.done = done_q;
    assign cfg_i.err  = err_q;

    // one outstanding transaction at a time
    a_no_rd_wr_overlap : assert property (
        @(posedge clk) disable iff (!rst_n_i) !(m_arvalid_o && m_awvalid_o)
    );

    // read address held while the memory stalls
    a_araddr_stable : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o)
    );

endmodule

`default_nettype wire

/* design/dma_regs.sv */
`default_nettype none

module dma_regs #(
    parameter int QTY_W = 16
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // axi4-lite slave, cpu side
    input  logic [dma_pkg::ADDR_W-1:0] s_awaddr_i,
    input  logic                       s_awvalid_i,
    output logic                       s_awready_o,
    input  logic [dma_pkg::DATA_W-1:0] s_wdata_i,
    input  logic                       s_wvalid_i,
    output logic                       s_wready_o,
    output dma_pkg::axi_resp_t         s_bresp_o,
    output logic                       s_bvalid_o,
    input  logic                       s_bready_i,
    input  logic [dma_pkg::ADDR_W-1:0] s_araddr_i,
    input  logic                       s_arvalid_i,
    output logic                       s_arready_o,
    output logic [dma_pkg::DATA_W-1:0] s_rdata_o,
    output dma_pkg::axi_resp_t         s_rresp_o,
    output logic                       s_rvalid_o,
    input  logic                       s_rready_i,
    dma_cfg_if.regs                    cfg_o,
    output logic                       int_o
);
    import dma_pkg::*;

    logic              awready_q;
    logic              bvalid_q;
    logic              arready_q;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;
    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic [QTY_W-1:0]  qty_q;
    logic              start_q;
    logic              done_q;
    logic              err_q;
    logic              wr_en;
    logic              rd_en;
    logic              ctrl_wr;
    logic [DATA_W-1:0] stat_w;

    // handshake edges, valids are held so payload is stable here
    assign wr_en   = awready_q && s_awvalid_i && s_wvalid_i;
    assign rd_en   = arready_q && s_arvalid_i;
    assign ctrl_wr = wr_en && (s_awaddr_i[REG_AW-1:0] == REG_CTRL);

    // status word as seen on a ctrl read
    always_comb begin
        stat_w                = '0;
        stat_w[STAT_BUSY_BIT] = cfg_o.busy;
        stat_w[STAT_DONE_BIT] = done_q;
        stat_w[STAT_ERR_BIT]  = err_q;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            // aw and w accepted together, one-cycle ready pulse
            // held off while a write response is still pending
            awready_q <= !awready_q && !bvalid_q && s_awvalid_i && s_wvalid_i;
            if (wr_en) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            // read side, same pattern
            arready_q <= !arready_q && !rvalid_q && s_arvalid_i;
            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
            // start only when idle, a start during a copy is dropped
            start_q <= ctrl_wr && s_wdata_i[CTRL_START_BIT] && !cfg_o.busy && !start_q;
            // new completion wins over a software clear in the same cycle
            if (cfg_o.done) begin
                done_q <= 1'b1;
                err_q  <= cfg_o.err;
            end else if (ctrl_wr && s_wdata_i[STAT_DONE_BIT]) begin
                done_q <= 1'b0;
                err_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (s_awaddr_i[REG_AW-1:0])
                REG_SRC: src_q <= s_wdata_i;
                REG_DST: dst_q <= s_wdata_i;
                REG_QTY: qty_q <= s_wdata_i[QTY_W-1:0];
                default: ;
            endcase
        end
        if (rd_en) begin
            case (s_araddr_i[REG_AW-1:0])
                REG_SRC:  rdata_q <= src_q;
                REG_DST:  rdata_q <= dst_q;
                REG_QTY:  rdata_q <= DATA_W'(qty_q);
                REG_CTRL: rdata_q <= stat_w;
                // holes in the window read as zero
                default:  rdata_q <= '0;
            endcase
        end
    end

    assign s_awready_o = awready_q;
    assign s_wready_o  = awready_q;
    assign s_bresp_o   = OKAY;
    assign s_bvalid_o  = bvalid_q;
    assign s_arready_o = arready_q;
    assign s_rdata_o   = rdata_q;
    assign s_rresp_o   = OKAY;
    assign s_rvalid_o  = rvalid_q;

    assign cfg_o.start    = start_q;
    assign cfg_o.src_addr = src_q;
    assign cfg_o.dst_addr = dst_q;
    assign cfg_o.qty      = qty_q;

    // sticky done is the interrupt
    assign int_o = done_q;

    // engine must be idle whenever a start goes out
    a_start_idle : assert property (
        @(posedge clk) disable iff (!rst_n_i) cfg_o.start |-> !cfg_o.busy
    );

    // write response held until the cpu takes it
    a_bvalid_hold : assert property (
        @(posedge clk) disable iff (!rst_n_i) s_bvalid_o && !s_bready_i |=> s_bvalid_o
    );

endmodule

`default_nettype wire

/* design/dma_cfg_if.sv */
`default_nettype none

interface dma_cfg_if #(
    parameter int QTY_W = 16
) ();
    import dma_pkg::*;

    // from the register block
    // start is a single-cycle pulse, only sent while idle
    logic              start;
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dst_addr;
    logic [QTY_W-1:0]  qty;

    // from the copy engine
    // done pulses once, busy drops in the same cycle
    logic busy;
    logic done;
    // qualified by done
    logic err;

    modport regs (
        output start, src_addr, dst_addr, qty,
        input  busy, done, err
    );

    modport engine (
        input  start, src_addr, dst_addr, qty,
        output busy, done, err
    );

endinterface

`default_nettype wire

/* design/dma_pkg.sv */
`default_nettype none

package dma_pkg;

    // axi4-lite bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // register window is 32 bytes
    // upper address bits are not decoded
    localparam int REG_AW = 5;

    // register byte offsets
    localparam logic [REG_AW-1:0] REG_SRC  = 5'h00;
    localparam logic [REG_AW-1:0] REG_DST  = 5'h04;
    localparam logic [REG_AW-1:0] REG_QTY  = 5'h08;
    localparam logic [REG_AW-1:0] REG_CTRL = 5'h0c;

    // ctrl write side
    localparam int CTRL_START_BIT = 0;

    // ctrl read side, status
    // writing 1 to the done bit clears done and err
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;
    localparam int STAT_ERR_BIT  = 2;

    // only the codes this design uses
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // copy engine states, one word per rd/wr round
    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_REQ,
        WR_RESP,
        FINISH
    } dma_state_t;

endpackage

`default_nettype wire
